// ==== ccc_handler.f ====
design/ccc_pkg.sv
design/ccc_addr_match.sv
design/ccc_fsm.sv
design/ccc_get_tx.sv
design/ccc_set_apply.sv
design/ccc_top.sv
verification/ccc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ccc_tb -f ccc_handler.f \
  -o ccc_sim > build.log 2>&1 \
  && ./obj_dir/ccc_sim > sim.log 2>&1 \
  || echo "Build or simulation ended with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/ccc_tb.sv ====
// Testbench for the CCC handler, plays the bus engines and checks the DUT with concurrent assertions
`timescale 1ns/1ps

module ccc_tb;

  localparam int RxBit = 0;
  localparam int RxByte = 1;
  localparam int TxBit = 2;
  localparam int TxByte = 3;
  localparam int Timeout = 200;

  logic clk_i, rst_ni;
  logic [ccc_pkg::ByteW-1:0] ccc_i, bus_tx_req_value_o, bus_rx_data_i, get_bcr_i, get_dcr_i;
  logic ccc_valid_i, done_fsm_o, bus_rstart_det_i, bus_stop_det_i;
  logic bus_tx_done_i, bus_tx_req_byte_o, bus_tx_req_bit_o, bus_tx_sel_od_pp_o;
  logic bus_rx_done_i, bus_rx_req_bit_o, bus_rx_req_byte_o;
  logic [ccc_pkg::AddrW-1:0] dyn_addr_i, sta_addr_i;
  logic dyn_addr_valid_i, sta_addr_valid_i;
  logic enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o, disec_hj_o, rstdaa_o;
  logic set_mwl_o, set_mrl_o;
  logic [ccc_pkg::LenW-1:0] mwl_o, mrl_o, get_mwl_i, get_mrl_i;
  logic [ccc_pkg::PidW-1:0] get_pid_i;

  // Expected values, set by the stimulus before each transfer
  int seed = 32'h0929_2a8d;
  logic [7:0] exp_tx_value = '0;
  logic exp_push_pull = 1'b0;
  logic [15:0] exp_mwl = '0, exp_mrl = '0;
  logic [2:0] exp_enec = '0, exp_disec = '0;
  int exp_n_mwl = 0, exp_n_mrl = 0, exp_n_rstdaa = 0;
  int n_set_mwl = 0, n_set_mrl = 0, n_rstdaa = 0;
  logic no_data_exp = 1'b0, rsvd_mode = 1'b0;
  logic [7:0] b0, b1;

  ccc_top #(.MaxGetBytes(8)) i_ccc_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  function automatic logic req_active(input int kind);
    case (kind)
      RxBit: return bus_rx_req_bit_o;
      RxByte: return bus_rx_req_byte_o;
      TxBit: return bus_tx_req_bit_o;
      default: return bus_tx_req_byte_o;
    endcase
  endfunction

  // Polls at edge plus 1 ns, where the requests are settled
  task automatic wait_req(input int kind);
    int n;
    n = 0;
    while (!req_active(kind)) begin
      if (n == Timeout) stop_on_error("Timeout, the DUT never raised the expected bus request");
      @(posedge clk_i);
      #1;
      n++;
    end
  endtask

  // RX engine, one-cycle done with the data
  task automatic answer_rx(input int kind, input logic [7:0] data);
    wait_req(kind);
    bus_rx_data_i = data;
    bus_rx_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rx_done_i = 1'b0;
  endtask

  // TX engine, value is checked at the done edge
  task automatic answer_tx(input int kind, input logic [7:0] value);
    exp_tx_value = value;
    wait_req(kind);
    // Bytes take a few cycles on the bus
    if (kind == TxByte) begin
      repeat (2) begin
        @(posedge clk_i);
        #1;
      end
    end
    bus_tx_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_tx_done_i = 1'b0;
  endtask

  // Controller traffic that the DUT did not ask for
  task automatic push_unrequested_rx(input logic [7:0] data);
    bus_rx_data_i = data;
    bus_rx_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rx_done_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_ccc(input logic [7:0] code);
    ccc_i = code;
    ccc_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    ccc_valid_i = 1'b0;
    // CCC T-bit, value arrives in bit 7
    answer_rx(RxBit, 8'h80);
  endtask

  // Sr, address byte and the ACK bit
  task automatic address_phase(input logic [6:0] addr, input logic rnw, input logic ack);
    wait_req(RxByte);
    bus_rstart_det_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rstart_det_i = 1'b0;
    answer_rx(RxByte, {addr, rnw});
    // ACK is open drain
    exp_push_pull = 1'b0;
    answer_tx(TxBit, {7'b0, ack});
  endtask

  task automatic write_bytes(input int n, input logic [7:0] d0, input logic [7:0] d1);
    answer_rx(RxByte, d0);
    answer_rx(RxBit, 8'h00);
    if (n > 1) begin
      answer_rx(RxByte, d1);
      answer_rx(RxBit, 8'h00);
    end
  endtask

  // MSB first, T-bit low only after the last byte
  task automatic read_bytes(input int n, input logic [47:0] data);
    int i;
    // Read data and T-bits are push-pull
    exp_push_pull = 1'b1;
    for (i = 0; i < n; i++) begin
      answer_tx(TxByte, data[8*(n-1-i) +: 8]);
      answer_tx(TxBit, {7'b0, i != n - 1});
    end
  endtask

  // STOP, done, then Idle and WaitCcc
  task automatic finish_ccc();
    int n;
    bus_stop_det_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_stop_det_i = 1'b0;
    n = 0;
    while (!done_fsm_o) begin
      if (n == Timeout) stop_on_error("Timeout, done_fsm_o never rose after the STOP");
      @(posedge clk_i);
      #1;
      n++;
    end
    repeat (2) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Pulse counters
  always @(posedge clk_i) begin
    if (set_mwl_o) n_set_mwl <= n_set_mwl + 1;
    if (set_mrl_o) n_set_mrl <= n_set_mrl + 1;
    if (rstdaa_o) n_rstdaa <= n_rstdaa + 1;
  end

  a_mwl: assert property (@(posedge clk_i) disable iff (!rst_ni) set_mwl_o |-> mwl_o == exp_mwl)
    else stop_on_error($sformatf("** Error: mwl_o = 0x%h, expected 0x%h", $sampled(mwl_o), exp_mwl));
  a_mrl: assert property (@(posedge clk_i) disable iff (!rst_ni) set_mrl_o |-> mrl_o == exp_mrl)
    else stop_on_error($sformatf("** Error: mrl_o = 0x%h, expected 0x%h", $sampled(mrl_o), exp_mrl));
  a_pulses: assert property (@(posedge clk_i) disable iff (!rst_ni) done_fsm_o |->
    n_set_mwl == exp_n_mwl && n_set_mrl == exp_n_mrl && n_rstdaa == exp_n_rstdaa)
    else stop_on_error("Wrong number of set_mwl_o, set_mrl_o or rstdaa_o pulses in this CCC");
  a_enec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_o |-> {enec_hj_o, enec_crr_o, enec_ibi_o} == exp_enec)
    else stop_on_error($sformatf("** Error: enec {hj,crr,ibi} = 0x%h, expected 0x%h",
      $sampled({enec_hj_o, enec_crr_o, enec_ibi_o}), exp_enec));
  a_disec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_o |-> {disec_hj_o, disec_crr_o, disec_ibi_o} == exp_disec)
    else stop_on_error($sformatf("** Error: disec {hj,crr,ibi} = 0x%h, expected 0x%h",
      $sampled({disec_hj_o, disec_crr_o, disec_ibi_o}), exp_disec));
  // ACK, data bytes and T-bits
  a_tx_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_tx_done_i |-> bus_tx_req_value_o == exp_tx_value)
    else stop_on_error($sformatf("** Error: bus_tx_req_value_o = 0x%h, expected 0x%h",
      $sampled(bus_tx_req_value_o), exp_tx_value));
  a_tx_drive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_tx_done_i |-> bus_tx_sel_od_pp_o == exp_push_pull)
    else stop_on_error($sformatf("** Error: bus_tx_sel_od_pp_o = 0x%h, expected 0x%h",
      $sampled(bus_tx_sel_od_pp_o), exp_push_pull));
  a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(bus_tx_req_byte_o && !bus_tx_done_i && !bus_stop_det_i && !bus_rstart_det_i) |->
    bus_tx_req_byte_o && bus_tx_req_value_o == $past(bus_tx_req_value_o))
    else stop_on_error("TX byte request dropped or changed value before bus_tx_done_i");
  a_no_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    no_data_exp |-> !bus_rx_req_byte_o && !bus_tx_req_byte_o)
    else stop_on_error("Byte request after a NACKed foreign address");
  a_set_stable: assert property (@(posedge clk_i) disable iff (!rst_ni) rsvd_mode |->
    $stable({set_mwl_o, mwl_o, set_mrl_o, mrl_o, enec_ibi_o, enec_crr_o, enec_hj_o,
             disec_ibi_o, disec_crr_o, disec_hj_o, rstdaa_o}))
    else stop_on_error("A SET output changed after the reserved address");
  a_done_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(bus_stop_det_i) |-> done_fsm_o)
    else stop_on_error("done_fsm_o was not high one cycle after the STOP");
  a_done_width: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_o |-> $past(bus_stop_det_i) && !$past(done_fsm_o))
    else stop_on_error("done_fsm_o high without a STOP one cycle earlier or for over one cycle");
  // Quiet bus in reset, in DoneCcc and in Idle
  a_req_low: assert property (@(posedge clk_i) (!rst_ni || done_fsm_o || $past(done_fsm_o)) |->
    !(bus_rx_req_bit_o || bus_rx_req_byte_o || bus_tx_req_bit_o || bus_tx_req_byte_o))
    else stop_on_error("Bus request high during reset or around done_fsm_o");

  initial begin
    rst_ni = 1'b0;
    ccc_i = '0;
    ccc_valid_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rx_data_i = '0;
    bus_rx_done_i = 1'b0;
    dyn_addr_i = 7'h2A;
    dyn_addr_valid_i = 1'b1;
    sta_addr_i = 7'h51;
    sta_addr_valid_i = 1'b1;
    get_mwl_i = 16'($random(seed));
    get_mrl_i = 16'($random(seed));
    get_pid_i = {16'($random(seed)), 32'($random(seed))};
    get_bcr_i = rand_byte();
    get_dcr_i = rand_byte();
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      #1;
    end

    // Broadcast SETMWL, then direct SETMRL to us
    b0 = rand_byte();
    b1 = rand_byte();
    exp_mwl = {b0, b1};
    exp_n_mwl++;
    start_ccc(ccc_pkg::BcastSetmwl);
    write_bytes(2, b0, b1);
    finish_ccc();
    b0 = rand_byte();
    b1 = rand_byte();
    exp_mrl = {b0, b1};
    exp_n_mrl++;
    start_ccc(ccc_pkg::DirectSetmrl);
    address_phase(dyn_addr_i, 1'b0, 1'b0);
    write_bytes(2, b0, b1);
    finish_ccc();

    // Event bits 0, 1 and 3
    b0 = rand_byte();
    exp_enec = {b0[3], b0[1], b0[0]};
    start_ccc(ccc_pkg::BcastEnec);
    write_bytes(1, b0, 8'h00);
    finish_ccc();
    b0 = rand_byte();
    exp_disec = {b0[3], b0[1], b0[0]};
    start_ccc(ccc_pkg::DirectDisec);
    address_phase(dyn_addr_i, 1'b0, 1'b0);
    write_bytes(1, b0, 8'h00);
    finish_ccc();
    exp_n_rstdaa++;
    start_ccc(ccc_pkg::BcastRstdaa);
    finish_ccc();

    // GETs to us, MRL ends with the fixed 8'hFF
    start_ccc(ccc_pkg::DirectGetpid);
    address_phase(dyn_addr_i, 1'b1, 1'b0);
    read_bytes(6, get_pid_i);
    finish_ccc();
    start_ccc(ccc_pkg::DirectGetmrl);
    address_phase(dyn_addr_i, 1'b1, 1'b0);
    read_bytes(3, {24'h0, get_mrl_i, 8'hFF});
    finish_ccc();

    // Foreign address gets a NACK
    start_ccc(ccc_pkg::DirectGetbcr);
    address_phase(7'h33, 1'b1, 1'b1);
    no_data_exp = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    no_data_exp = 1'b0;
    finish_ccc();

    // Reserved address, then two stray data bytes with their T-bits
    rsvd_mode = 1'b1;
    start_ccc(ccc_pkg::DirectSetmwl);
    address_phase(ccc_pkg::RsvdAddr, 1'b0, 1'b0);
    push_unrequested_rx(rand_byte());
    push_unrequested_rx(8'h00);
    push_unrequested_rx(rand_byte());
    push_unrequested_rx(8'h00);
    repeat (3) @(posedge clk_i);
    #1;
    finish_ccc();
    rsvd_mode = 1'b0;

    // STOP before the T-bit of the first byte
    start_ccc(ccc_pkg::BcastSetmrl);
    answer_rx(RxByte, rand_byte());
    finish_ccc();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/ccc_top.sv ====
// CCC handler top, wires address match, transfer FSM, GET server and SET bank to the bus engines
`timescale 1ns/1ps

module ccc_top #(
  parameter int MaxGetBytes = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Handoff from the primary target FSM
  input  logic [ccc_pkg::ByteW-1:0] ccc_i,
  input  logic                      ccc_valid_i,
  output logic                      done_fsm_o,
  // Bus monitor
  input  logic                      bus_rstart_det_i,
  input  logic                      bus_stop_det_i,
  // Bus TX engine
  input  logic                      bus_tx_done_i,
  output logic                      bus_tx_req_byte_o,
  output logic                      bus_tx_req_bit_o,
  output logic [ccc_pkg::ByteW-1:0] bus_tx_req_value_o,
  output logic                      bus_tx_sel_od_pp_o,
  // Bus RX engine
  input  logic [ccc_pkg::ByteW-1:0] bus_rx_data_i,
  input  logic                      bus_rx_done_i,
  output logic                      bus_rx_req_bit_o,
  output logic                      bus_rx_req_byte_o,
  // Target addresses
  input  logic [ccc_pkg::AddrW-1:0] dyn_addr_i,
  input  logic                      dyn_addr_valid_i,
  input  logic [ccc_pkg::AddrW-1:0] sta_addr_i,
  input  logic                      sta_addr_valid_i,
  // SET results
  output logic                      enec_ibi_o,
  output logic                      enec_crr_o,
  output logic                      enec_hj_o,
  output logic                      disec_ibi_o,
  output logic                      disec_crr_o,
  output logic                      disec_hj_o,
  output logic                      rstdaa_o,
  output logic                      set_mwl_o,
  output logic [ccc_pkg::LenW-1:0]  mwl_o,
  output logic                      set_mrl_o,
  output logic [ccc_pkg::LenW-1:0]  mrl_o,
  // GET sources
  input  logic [ccc_pkg::LenW-1:0]  get_mwl_i,
  input  logic [ccc_pkg::LenW-1:0]  get_mrl_i,
  input  logic [ccc_pkg::PidW-1:0]  get_pid_i,
  input  logic [ccc_pkg::ByteW-1:0] get_bcr_i,
  input  logic [ccc_pkg::ByteW-1:0] get_dcr_i
);

  ccc_pkg::ccc_state_e       state_q;
  logic [ccc_pkg::ByteW-1:0] command_code, tx_byte;
  logic addr_ours, addr_rsvd, cmd_rnw, tx_last;

  ccc_addr_match i_addr_match (
    .clk_i, .rst_ni, .state_i(state_q), .bus_rx_done_i, .bus_rx_data_i,
    .dyn_addr_i, .dyn_addr_valid_i, .sta_addr_i, .sta_addr_valid_i,
    .addr_ours_o(addr_ours), .addr_rsvd_o(addr_rsvd), .cmd_rnw_o(cmd_rnw)
  );

  ccc_fsm i_fsm (
    .clk_i, .rst_ni, .ccc_i, .ccc_valid_i, .bus_rx_done_i, .bus_tx_done_i,
    .bus_rstart_det_i, .bus_stop_det_i, .addr_ours_i(addr_ours), .addr_rsvd_i(addr_rsvd),
    .cmd_rnw_i(cmd_rnw), .tx_byte_i(tx_byte), .tx_last_i(tx_last),
    .command_code_o(command_code), .state_o(state_q), .done_fsm_o,
    .bus_rx_req_bit_o, .bus_rx_req_byte_o, .bus_tx_req_bit_o, .bus_tx_req_byte_o,
    .bus_tx_req_value_o, .bus_tx_sel_od_pp_o
  );

  ccc_get_tx #(
    .MaxGetBytes(MaxGetBytes)
  ) i_get_tx (
    .clk_i, .rst_ni, .state_i(state_q), .command_code_i(command_code), .bus_tx_done_i,
    .get_bcr_i, .get_dcr_i, .get_mwl_i, .get_mrl_i, .get_pid_i,
    .tx_byte_o(tx_byte), .tx_last_o(tx_last)
  );

  ccc_set_apply i_set_apply (
    .clk_i, .rst_ni, .state_i(state_q), .command_code_i(command_code), .ccc_valid_i,
    .bus_rx_done_i, .bus_rx_data_i, .addr_rsvd_i(addr_rsvd),
    .set_mwl_o, .mwl_o, .set_mrl_o, .mrl_o,
    .enec_ibi_o, .enec_crr_o, .enec_hj_o, .disec_ibi_o, .disec_crr_o, .disec_hj_o,
    .rstdaa_o
  );

endmodule

// ==== design/ccc_set_apply.sv ====
// SET register bank, captures CCC write data and drives the ENEC/DISEC, MWL/MRL and RSTDAA outputs
`timescale 1ns/1ps

module ccc_set_apply (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  ccc_pkg::ccc_state_e       state_i,
  input  logic [ccc_pkg::ByteW-1:0] command_code_i,
  input  logic                      ccc_valid_i,
  input  logic                      bus_rx_done_i,
  input  logic [ccc_pkg::ByteW-1:0] bus_rx_data_i,
  input  logic                      addr_rsvd_i,
  output logic                      set_mwl_o,
  output logic [ccc_pkg::LenW-1:0]  mwl_o,
  output logic                      set_mrl_o,
  output logic [ccc_pkg::LenW-1:0]  mrl_o,
  output logic                      enec_ibi_o,
  output logic                      enec_crr_o,
  output logic                      enec_hj_o,
  output logic                      disec_ibi_o,
  output logic                      disec_crr_o,
  output logic                      disec_hj_o,
  output logic                      rstdaa_o
);

  logic [ccc_pkg::ByteW-1:0] rx_byte_q;
  // Saturates at 2, only the first two bytes matter
  logic [1:0] byte_cnt_q;
  logic data_done, is_mwl, is_mrl, is_enec, is_disec;

  // T-bit after a data byte, skipped behind a reserved address
  assign data_done = (state_i == ccc_pkg::RxDataTbit) && bus_rx_done_i && !addr_rsvd_i;

  assign is_mwl   = command_code_i inside {ccc_pkg::BcastSetmwl, ccc_pkg::DirectSetmwl};
  assign is_mrl   = command_code_i inside {ccc_pkg::BcastSetmrl, ccc_pkg::DirectSetmrl};
  assign is_enec  = command_code_i inside {ccc_pkg::BcastEnec, ccc_pkg::DirectEnec};
  assign is_disec = command_code_i inside {ccc_pkg::BcastDisec, ccc_pkg::DirectDisec};

  always_ff @(posedge clk_i) begin
    if (state_i == ccc_pkg::RxData && bus_rx_done_i) rx_byte_q <= bus_rx_data_i;
  end

  // Restart per CCC and per address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
    end else if (ccc_valid_i || (state_i == ccc_pkg::RxDirectAddr && bus_rx_done_i)) begin
      byte_cnt_q <= '0;
    end else if (data_done && byte_cnt_q != 2'd2) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end
  end

  // Lengths arrive high byte first
  always_ff @(posedge clk_i) begin
    if (data_done && byte_cnt_q == 2'd0) begin
      if (is_mwl) mwl_o[15:8] <= rx_byte_q;
      if (is_mrl) mrl_o[15:8] <= rx_byte_q;
    end
    if (data_done && byte_cnt_q == 2'd1) begin
      if (is_mwl) mwl_o[7:0] <= rx_byte_q;
      if (is_mrl) mrl_o[7:0] <= rx_byte_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o   <= 1'b0;
      set_mrl_o   <= 1'b0;
      rstdaa_o    <= 1'b0;
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
    end else begin
      // Pulse once the low byte is in
      set_mwl_o <= data_done && is_mwl && byte_cnt_q == 2'd1;
      set_mrl_o <= data_done && is_mrl && byte_cnt_q == 2'd1;
      // RSTDAA has no data, act on the CCC T-bit
      rstdaa_o  <= (state_i == ccc_pkg::RxTbit) && bus_rx_done_i &&
                   command_code_i == ccc_pkg::BcastRstdaa;
      // Event bits: 0 IBI, 1 CRR, 3 HJ
      if (data_done && byte_cnt_q == 2'd0 && is_enec) begin
        enec_ibi_o <= rx_byte_q[0];
        enec_crr_o <= rx_byte_q[1];
        enec_hj_o  <= rx_byte_q[3];
      end
      if (data_done && byte_cnt_q == 2'd0 && is_disec) begin
        disec_ibi_o <= rx_byte_q[0];
        disec_crr_o <= rx_byte_q[1];
        disec_hj_o  <= rx_byte_q[3];
      end
    end
  end

endmodule

// ==== design/ccc_get_tx.sv ====
// GET read data server, counts bytes down and picks the next byte MSB first for the FSM
`timescale 1ns/1ps

module ccc_get_tx #(
  parameter int MaxGetBytes = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  ccc_pkg::ccc_state_e       state_i,
  input  logic [ccc_pkg::ByteW-1:0] command_code_i,
  input  logic                      bus_tx_done_i,
  input  logic [ccc_pkg::ByteW-1:0] get_bcr_i,
  input  logic [ccc_pkg::ByteW-1:0] get_dcr_i,
  input  logic [ccc_pkg::LenW-1:0]  get_mwl_i,
  input  logic [ccc_pkg::LenW-1:0]  get_mrl_i,
  input  logic [ccc_pkg::PidW-1:0]  get_pid_i,
  output logic [ccc_pkg::ByteW-1:0] tx_byte_o,
  output logic                      tx_last_o
);

  logic [MaxGetBytes-1:0] cnt_q, cnt_init;

  // Reload during the ACK bit, count down per sent byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (state_i == ccc_pkg::TxAddrAck) begin
      cnt_q <= cnt_init;
    end else if (state_i == ccc_pkg::TxData && bus_tx_done_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Count N selects the most significant byte
  always_comb begin
    cnt_init  = '0;
    tx_byte_o = '0;
    case (command_code_i)
      ccc_pkg::DirectGetbcr: begin
        cnt_init  = MaxGetBytes'(ccc_pkg::GetregBytes);
        tx_byte_o = get_bcr_i;
      end
      ccc_pkg::DirectGetdcr: begin
        cnt_init  = MaxGetBytes'(ccc_pkg::GetregBytes);
        tx_byte_o = get_dcr_i;
      end
      ccc_pkg::DirectGetmwl: begin
        cnt_init  = MaxGetBytes'(ccc_pkg::GetmwlBytes);
        tx_byte_o = (cnt_q == 2) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      end
      // Third byte is the max IBI payload, fixed at 255
      ccc_pkg::DirectGetmrl: begin
        cnt_init = MaxGetBytes'(ccc_pkg::GetmrlBytes);
        if (cnt_q == 3) tx_byte_o = get_mrl_i[15:8];
        else if (cnt_q == 2) tx_byte_o = get_mrl_i[7:0];
        else tx_byte_o = 8'hFF;
      end
      ccc_pkg::DirectGetpid: begin
        cnt_init = MaxGetBytes'(ccc_pkg::GetpidBytes);
        if (cnt_q != '0) tx_byte_o = get_pid_i[ccc_pkg::ByteW*(cnt_q-1) +: ccc_pkg::ByteW];
      end
      default: ;
    endcase
  end

  assign tx_last_o = (cnt_q == '0);

endmodule

// ==== design/ccc_fsm.sv ====
// CCC transfer FSM, takes over after the command code and drives the bus RX/TX requests
`timescale 1ns/1ps

module ccc_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [ccc_pkg::ByteW-1:0] ccc_i,
  input  logic                      ccc_valid_i,
  input  logic                      bus_rx_done_i,
  input  logic                      bus_tx_done_i,
  input  logic                      bus_rstart_det_i,
  input  logic                      bus_stop_det_i,
  input  logic                      addr_ours_i,
  input  logic                      addr_rsvd_i,
  input  logic                      cmd_rnw_i,
  input  logic [ccc_pkg::ByteW-1:0] tx_byte_i,
  input  logic                      tx_last_i,
  output logic [ccc_pkg::ByteW-1:0] command_code_o,
  output ccc_pkg::ccc_state_e       state_o,
  output logic                      done_fsm_o,
  output logic                      bus_rx_req_bit_o,
  output logic                      bus_rx_req_byte_o,
  output logic                      bus_tx_req_bit_o,
  output logic                      bus_tx_req_byte_o,
  output logic [ccc_pkg::ByteW-1:0] bus_tx_req_value_o,
  output logic                      bus_tx_sel_od_pp_o
);

  ccc_pkg::ccc_state_e state_q, state_d;
  logic [ccc_pkg::ByteW-1:0] command_code_q;
  logic is_direct;

  // Command code handed over by the primary FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      command_code_q <= '0;
    end else if (ccc_valid_i) begin
      command_code_q <= ccc_i;
    end
  end

  // Bit 7 marks direct CCCs
  assign is_direct = command_code_q[ccc_pkg::ByteW-1];

  always_comb begin
    state_d = state_q;
    case (state_q)
      ccc_pkg::Idle: state_d = ccc_pkg::WaitCcc;
      ccc_pkg::WaitCcc: if (ccc_valid_i) state_d = ccc_pkg::RxTbit;
      ccc_pkg::RxTbit: begin
        if (bus_rx_done_i) state_d = is_direct ? ccc_pkg::RxDirectByte : ccc_pkg::RxData;
      end
      // Direct CCC waits for Sr and the target address
      ccc_pkg::RxDirectByte: begin
        if (bus_rstart_det_i) state_d = ccc_pkg::RxDirectAddr;
        else if (bus_rx_done_i) state_d = ccc_pkg::RxDirectTbit;
      end
      ccc_pkg::RxDirectTbit: if (bus_rx_done_i) state_d = ccc_pkg::RxDirectByte;
      ccc_pkg::RxDirectAddr: if (bus_rx_done_i) state_d = ccc_pkg::TxAddrAck;
      ccc_pkg::TxAddrAck: begin
        if (bus_tx_done_i) begin
          if (addr_rsvd_i) state_d = ccc_pkg::WaitForStop;
          else if (addr_ours_i) state_d = cmd_rnw_i ? ccc_pkg::TxData : ccc_pkg::RxData;
          else state_d = ccc_pkg::WaitForBusCond;
        end
      end
      ccc_pkg::RxData: begin
        if (bus_rstart_det_i) state_d = ccc_pkg::RxDirectAddr;
        else if (bus_rx_done_i) state_d = ccc_pkg::RxDataTbit;
      end
      ccc_pkg::RxDataTbit: if (bus_rx_done_i) state_d = ccc_pkg::RxData;
      ccc_pkg::TxData: begin
        if (bus_rstart_det_i) state_d = ccc_pkg::RxDirectAddr;
        else if (bus_tx_done_i) state_d = ccc_pkg::TxDataTbit;
      end
      // Last T-bit ends the read, wait for Sr or STOP
      ccc_pkg::TxDataTbit: begin
        if (bus_tx_done_i) state_d = tx_last_i ? ccc_pkg::WaitForBusCond : ccc_pkg::TxData;
      end
      ccc_pkg::WaitForBusCond: if (bus_rstart_det_i) state_d = ccc_pkg::RxDirectAddr;
      // Only a STOP leaves this state
      ccc_pkg::WaitForStop: state_d = ccc_pkg::WaitForStop;
      ccc_pkg::DoneCcc: state_d = ccc_pkg::Idle;
      default: state_d = ccc_pkg::Idle;
    endcase
  end

  // STOP aborts from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ccc_pkg::Idle;
    end else if (bus_stop_det_i) begin
      state_q <= ccc_pkg::DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_value_o = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    case (state_q)
      ccc_pkg::RxTbit, ccc_pkg::RxDirectTbit, ccc_pkg::RxDataTbit: bus_rx_req_bit_o = 1'b1;
      ccc_pkg::RxDirectByte, ccc_pkg::RxDirectAddr, ccc_pkg::RxData: bus_rx_req_byte_o = 1'b1;
      // ACK low for ours and reserved, open drain
      ccc_pkg::TxAddrAck: begin
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {{(ccc_pkg::ByteW-1){1'b0}}, ~(addr_ours_i | addr_rsvd_i)};
      end
      ccc_pkg::TxData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = tx_byte_i;
        bus_tx_sel_od_pp_o = 1'b1;
      end
      // T-bit 0 on the last byte
      ccc_pkg::TxDataTbit: begin
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {{(ccc_pkg::ByteW-1){1'b0}}, ~tx_last_i};
        bus_tx_sel_od_pp_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign done_fsm_o     = (state_q == ccc_pkg::DoneCcc);
  assign state_o        = state_q;
  assign command_code_o = command_code_q;

  // Read byte stays on the bus until the TX engine takes it
  a_tx_byte_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_tx_req_byte_o && !bus_tx_done_i && !bus_rstart_det_i && !bus_stop_det_i |=>
    bus_tx_req_byte_o && $stable(bus_tx_req_value_o));

endmodule

// ==== design/ccc_addr_match.sv ====
// Direct CCC address capture and match, tells the FSM whether the address is ours or reserved
`timescale 1ns/1ps

module ccc_addr_match (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  ccc_pkg::ccc_state_e         state_i,
  input  logic                        bus_rx_done_i,
  input  logic [ccc_pkg::ByteW-1:0]   bus_rx_data_i,
  input  logic [ccc_pkg::AddrW-1:0]   dyn_addr_i,
  input  logic                        dyn_addr_valid_i,
  input  logic [ccc_pkg::AddrW-1:0]   sta_addr_i,
  input  logic                        sta_addr_valid_i,
  output logic                        addr_ours_o,
  output logic                        addr_rsvd_o,
  output logic                        cmd_rnw_o
);

  logic [ccc_pkg::AddrW-1:0] addr_q;
  // Address seen in this CCC
  logic                      addr_vld_q;

  // Address byte is {addr, RnW}
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      cmd_rnw_o  <= 1'b0;
      addr_vld_q <= 1'b0;
    end else if (state_i == ccc_pkg::RxDirectAddr && bus_rx_done_i) begin
      addr_q     <= bus_rx_data_i[ccc_pkg::ByteW-1:1];
      cmd_rnw_o  <= bus_rx_data_i[0];
      addr_vld_q <= 1'b1;
    end else if (state_i == ccc_pkg::DoneCcc) begin
      // Forget the address once the CCC ends
      addr_vld_q <= 1'b0;
    end
  end

  // Dynamic address wins, static only before DAA
  always_comb begin
    addr_ours_o = 1'b0;
    if (dyn_addr_valid_i) begin
      addr_ours_o = addr_vld_q && (addr_q == dyn_addr_i);
    end else if (sta_addr_valid_i) begin
      addr_ours_o = addr_vld_q && (addr_q == sta_addr_i);
    end
  end

  assign addr_rsvd_o = addr_vld_q && (addr_q == ccc_pkg::RsvdAddr);

  // ACK decision must never see both flags
  a_ours_rsvd_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == ccc_pkg::TxAddrAck |-> !(addr_ours_o && addr_rsvd_o));

endmodule

// ==== design/ccc_pkg.sv ====
// Shared CCC codes, widths and FSM states, referenced by scoped name from RTL and testbench
package ccc_pkg;

  // Bus and payload widths
  localparam int ByteW = 8;
  localparam int AddrW = 7;
  localparam int PidW = 48;
  localparam int LenW = 16;

  // Broadcast address, reserved for target matching
  localparam logic [AddrW-1:0] RsvdAddr = 7'h7E;

  // Broadcast command codes, bit 7 clear
  localparam logic [ByteW-1:0] BcastEnec = 8'h00;
  localparam logic [ByteW-1:0] BcastDisec = 8'h01;
  localparam logic [ByteW-1:0] BcastRstdaa = 8'h06;
  localparam logic [ByteW-1:0] BcastSetmwl = 8'h09;
  localparam logic [ByteW-1:0] BcastSetmrl = 8'h0A;

  // Direct command codes, bit 7 set
  localparam logic [ByteW-1:0] DirectEnec = 8'h80;
  localparam logic [ByteW-1:0] DirectDisec = 8'h81;
  localparam logic [ByteW-1:0] DirectSetmwl = 8'h89;
  localparam logic [ByteW-1:0] DirectSetmrl = 8'h8A;
  localparam logic [ByteW-1:0] DirectGetmwl = 8'h8B;
  localparam logic [ByteW-1:0] DirectGetmrl = 8'h8C;
  localparam logic [ByteW-1:0] DirectGetpid = 8'h8D;
  localparam logic [ByteW-1:0] DirectGetbcr = 8'h8E;
  localparam logic [ByteW-1:0] DirectGetdcr = 8'h8F;

  // GET payload lengths, loaded into the byte counter
  localparam logic [ByteW-1:0] GetregBytes = 8'd1;
  localparam logic [ByteW-1:0] GetmwlBytes = 8'd2;
  localparam logic [ByteW-1:0] GetmrlBytes = 8'd3;
  localparam logic [ByteW-1:0] GetpidBytes = 8'd6;

  // CCC transfer states
  typedef enum logic [4:0] {
    Idle, WaitCcc, RxTbit, RxDirectByte, RxDirectTbit, RxDirectAddr, TxAddrAck,
    RxData, RxDataTbit, TxData, TxDataTbit, WaitForBusCond, WaitForStop, DoneCcc
  } ccc_state_e;

endpackage
